//--- hdl/ps2_pkg.sv
/*
 * PS/2 host port shared definitions: frame and timer constants,
 * vector types, the line FSM states and the inter-block structs
 */
`default_nettype none

package ps2_pkg;

  // ------------------------------------------------------------------
  // vector types
  // ------------------------------------------------------------------

  // one data byte as it travels over the wire
  typedef logic [7:0]  scan_code_t;

  // index of the current bit inside a frame
  typedef logic [3:0]  bit_count_t;

  // clk cycles per timer tick, set at run time by the host
  typedef logic [15:0] divide_t;

  // tick counts used by the inhibit and settle timers
  typedef logic [3:0]  tick_count_t;

  // ------------------------------------------------------------------
  // constants
  // ------------------------------------------------------------------

  // start, 8 data bits, parity and stop
  localparam int FRAME_BITS = 11;

  // the whole frame sits in the shift register, start bit at bit 0
  typedef logic [FRAME_BITS-1:0] frame_t;

  // inhibit period and receive watchdog, 60 us at a 5 us tick
  localparam tick_count_t INHIBIT_TICKS = 4'd12;

  // the device clock must sit at its new level this many ticks
  // before a transmit edge is taken as real
  localparam tick_count_t SETTLE_TICKS = 4'd1;

  // ------------------------------------------------------------------
  // line FSM
  // ------------------------------------------------------------------

  // rx states follow the device clock, tx states run the host-to-device
  // request and then follow the device clock the same way
  typedef enum logic [3:0] {
    rx_clk_h,
    rx_clk_l,
    rx_fall_mark,
    rx_rise_mark,
    tx_reset_timer,
    tx_force_clk_l,
    tx_first_wait_clk_h,
    tx_wait_clk_h,
    tx_rise_mark,
    tx_clk_h,
    tx_clk_l,
    tx_wait_ack,
    tx_done_recovery,
    tx_error_no_ack
  } ps2_state_e;

  // ------------------------------------------------------------------
  // structs between the blocks
  // ------------------------------------------------------------------

  // timer enables from the frame engine, low clears the count
  typedef struct packed {
    logic inhibit_en;
    logic settle_en;
  } timer_req_t;

  // timer limits reached, held while the enable stays high
  typedef struct packed {
    logic inhibit_done;
    logic settle_done;
  } timer_done_t;

  // one received scan code, valid strobes for a single clk
  typedef struct packed {
    logic       valid;
    scan_code_t code;
  } rx_word_t;

endpackage

`default_nettype wire

//--- hdl/ps2_tick_timer.sv
/*
 * PS/2 timing: a run-time prescaler makes the tick, which drives
 * the inhibit timer, and a settle timer debounces the device clock
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_tick_timer (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire ps2_pkg::divide_t      divide_i,
  input  wire ps2_pkg::timer_req_t   req_i,
  output      ps2_pkg::timer_done_t  done_o
);
  import ps2_pkg::*;

  divide_t     presc_cnt;
  logic        tick;
  tick_count_t inhibit_cnt;
  divide_t     settle_cyc;
  tick_count_t settle_cnt;
  logic        settle_wrap;

  // the prescaler only runs while the inhibit timer is wanted, so every
  // inhibit period starts on a fresh tick boundary
  assign tick = req_i.inhibit_en && (presc_cnt == divide_i - divide_t'(1));

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      presc_cnt <= '0;
    else if (!req_i.inhibit_en || tick)
      presc_cnt <= '0;
    else
      presc_cnt <= presc_cnt + divide_t'(1);
  end

  // counts ticks and parks at the limit until the enable drops
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      inhibit_cnt <= '0;
    else if (!req_i.inhibit_en)
      inhibit_cnt <= '0;
    else if (tick && (inhibit_cnt != INHIBIT_TICKS))
      inhibit_cnt <= inhibit_cnt + tick_count_t'(1);
  end

  // ------------------------------------------------------------------
  // settle timer, its own cycle counter so it can run without the tick
  // ------------------------------------------------------------------
  assign settle_wrap = (settle_cyc == divide_i - divide_t'(1));

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      settle_cyc <= '0;
      settle_cnt <= '0;
    end
    else if (!req_i.settle_en)
    begin
      settle_cyc <= '0;
      settle_cnt <= '0;
    end
    else if (settle_cnt != SETTLE_TICKS)
    begin
      // one full divide_i period per settle tick
      if (settle_wrap)
      begin
        settle_cyc <= '0;
        settle_cnt <= settle_cnt + tick_count_t'(1);
      end
      else
        settle_cyc <= settle_cyc + divide_t'(1);
    end
  end

  assign done_o.inhibit_done = req_i.inhibit_en && (inhibit_cnt == INHIBIT_TICKS);
  assign done_o.settle_done  = req_i.settle_en && (settle_cnt == SETTLE_TICKS);

endmodule

`default_nettype wire

//--- hdl/ps2_frame_engine.sv
/*
 * PS/2 frame engine: synchronizes the two lines and runs the line FSM,
 * bit counter and shift register for both receive and transmit
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_engine (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  ps2_clk_i,
  input  wire logic                  ps2_data_i,
  output      logic                  ps2_clk_oe_o,
  output      logic                  ps2_data_oe_o,
  input  wire ps2_pkg::scan_code_t   tx_data_i,
  input  wire logic                  tx_write_i,
  output      logic                  tx_write_ack_o,
  output      logic                  tx_error_no_ack_o,
  output      ps2_pkg::timer_req_t   timer_req_o,
  input  wire ps2_pkg::timer_done_t  timer_done_i,
  output      ps2_pkg::rx_word_t     rx_word_o
);
  import ps2_pkg::*;

  logic       clk_meta;
  logic       data_meta;
  logic       clk_s;
  logic       data_s;
  ps2_state_e state;
  ps2_state_e next_state;
  bit_count_t bit_count;
  frame_t     shift_q;
  logic       tx_parity;
  logic       rx_shift_done;
  logic       tx_shift_done;
  logic       shift_en;
  logic       watchdog;

  // ------------------------------------------------------------------
  // input synchronizers
  // ------------------------------------------------------------------

  // both lines idle high, so the flops come out of reset high and no
  // false falling edge is seen after reset
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      clk_meta  <= 1'b1;
      data_meta <= 1'b1;
      clk_s     <= 1'b1;
      data_s    <= 1'b1;
    end
    else
    begin
      clk_meta  <= ps2_clk_i;
      data_meta <= ps2_data_i;
      clk_s     <= clk_meta;
      data_s    <= data_meta;
    end
  end

  // ------------------------------------------------------------------
  // line FSM
  // ------------------------------------------------------------------
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      state <= rx_clk_h;
    else
      state <= next_state;
  end

  always_comb
  begin
    // lines released and timers cleared unless a state says otherwise
    next_state    = state;
    ps2_clk_oe_o  = 1'b0;
    ps2_data_oe_o = 1'b0;
    timer_req_o   = '0;
    case (state)
      // the inhibit timer doubles as the receive watchdog here
      rx_clk_h:
      begin
        timer_req_o.inhibit_en = 1'b1;
        if (tx_write_i)
          next_state = tx_reset_timer;
        else if (!clk_s)
          next_state = rx_fall_mark;
      end
      rx_clk_l:
      begin
        timer_req_o.inhibit_en = 1'b1;
        if (tx_write_i)
          next_state = tx_reset_timer;
        else if (clk_s)
          next_state = rx_rise_mark;
      end
      // markers last one clk, the watchdog restarts on every edge
      rx_fall_mark:
        next_state = rx_clk_l;
      rx_rise_mark:
        next_state = rx_clk_h;
      // one clk with the timer off so the inhibit period starts at zero
      tx_reset_timer:
        next_state = tx_force_clk_l;
      tx_force_clk_l:
      begin
        timer_req_o.inhibit_en = 1'b1;
        ps2_clk_oe_o           = 1'b1;
        if (timer_done_i.inhibit_done)
          next_state = tx_first_wait_clk_h;
      end
      // clock released, start bit on data, wait for the device to clock
      tx_first_wait_clk_h:
      begin
        timer_req_o.settle_en = 1'b1;
        ps2_data_oe_o         = 1'b1;
        if (!clk_s && timer_done_i.settle_done)
          next_state = tx_clk_l;
      end
      tx_wait_clk_h:
      begin
        timer_req_o.settle_en = 1'b1;
        ps2_data_oe_o         = !shift_q[0];
        if (clk_s && timer_done_i.settle_done)
          next_state = tx_rise_mark;
      end
      tx_rise_mark:
      begin
        ps2_data_oe_o = !shift_q[0];
        next_state    = tx_clk_h;
      end
      tx_clk_h:
      begin
        ps2_data_oe_o = !shift_q[0];
        if (tx_shift_done)
          next_state = tx_wait_ack;
        else if (!clk_s)
          next_state = tx_clk_l;
      end
      tx_clk_l:
      begin
        ps2_data_oe_o = !shift_q[0];
        if (clk_s)
          next_state = tx_wait_clk_h;
      end
      // the device answers by pulling data low during its last clock low
      tx_wait_ack:
      begin
        if (!clk_s && data_s)
          next_state = tx_error_no_ack;
        else if (!clk_s && !data_s)
          next_state = tx_done_recovery;
      end
      tx_done_recovery, tx_error_no_ack:
      begin
        if (clk_s && data_s)
          next_state = rx_clk_h;
      end
      default:
        next_state = rx_clk_h;
    endcase
  end

  assign tx_error_no_ack_o = (state == tx_error_no_ack);

  // the write is taken only while the line FSM is idle or receiving
  assign tx_write_ack_o = tx_write_i && ((state == rx_clk_h) || (state == rx_clk_l));

  // ------------------------------------------------------------------
  // bit counter
  // ------------------------------------------------------------------
  assign rx_shift_done = (bit_count == bit_count_t'(FRAME_BITS));
  assign tx_shift_done = (bit_count == bit_count_t'(FRAME_BITS - 1));
  assign shift_en      = (state == rx_fall_mark) || (state == tx_rise_mark);

  // device clock idle high for a whole inhibit period drops a partial frame
  assign watchdog = timer_done_i.inhibit_done && (state == rx_clk_h) && clk_s;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      bit_count <= '0;
    else if (rx_shift_done || (state == tx_wait_ack) || tx_write_ack_o)
      bit_count <= '0;
    else if (watchdog)
      bit_count <= '0;
    else if (shift_en)
      bit_count <= bit_count + bit_count_t'(1);
  end

  // ------------------------------------------------------------------
  // shift register
  // ------------------------------------------------------------------

  // odd parity over the command byte
  assign tx_parity = ~^tx_data_i;

  // bit 0 is the next bit on the wire when sending, received bits enter
  // at the top so a full frame ends with the start bit at bit 0
  always_ff @(posedge clk)
  begin
    if (tx_write_ack_o)
      shift_q <= {1'b1, tx_parity, tx_data_i, 1'b0};
    else if (shift_en)
      shift_q <= {data_s, shift_q[FRAME_BITS-1:1]};
  end

  assign rx_word_o.valid = rx_shift_done;
  assign rx_word_o.code  = shift_q[8:1];

endmodule

`default_nettype wire

//--- hdl/ps2_rx_holding.sv
/*
 * PS/2 receive holding stage: keeps the last scan code and a ready
 * flag that the host clears with a read pulse
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_rx_holding (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire ps2_pkg::rx_word_t    rx_word_i,
  input  wire logic                 rx_read_i,
  output      ps2_pkg::scan_code_t  rx_code_o,
  output      logic                 rx_ready_o
);

  // a newer code simply replaces an unread one
  always_ff @(posedge clk)
  begin
    if (rx_word_i.valid)
      rx_code_o <= rx_word_i.code;
  end

  // a strobe wins over a read in the same clk so new data is not hidden
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      rx_ready_o <= 1'b0;
    else if (rx_word_i.valid)
      rx_ready_o <= 1'b1;
    else if (rx_read_i)
      rx_ready_o <= 1'b0;
  end

endmodule

`default_nettype wire

//--- hdl/ps2_host_top.sv
/*
 * PS/2 host port top level: joins the tick timer, frame engine and
 * receive holding stage between the pins and the host bus
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_host_top (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire ps2_pkg::divide_t     divide_i,
  input  wire logic                 ps2_clk_i,
  input  wire logic                 ps2_data_i,
  output      logic                 ps2_clk_oe_o,
  output      logic                 ps2_data_oe_o,
  output      ps2_pkg::scan_code_t  rx_code_o,
  output      logic                 rx_ready_o,
  input  wire logic                 rx_read_i,
  input  wire ps2_pkg::scan_code_t  tx_data_i,
  input  wire logic                 tx_write_i,
  output      logic                 tx_write_ack_o,
  output      logic                 tx_error_no_ack_o
);
  import ps2_pkg::*;

  timer_req_t  timer_req;
  timer_done_t timer_done;
  rx_word_t    rx_word;

  // prescaler plus inhibit and settle timers
  ps2_tick_timer u_timer (
    .clk      (clk),
    .reset    (reset),
    .divide_i (divide_i),
    .req_i    (timer_req),
    .done_o   (timer_done)
  );

  // line FSM, bit counter and shift register
  ps2_frame_engine u_engine (
    .clk               (clk),
    .reset             (reset),
    .ps2_clk_i         (ps2_clk_i),
    .ps2_data_i        (ps2_data_i),
    .ps2_clk_oe_o      (ps2_clk_oe_o),
    .ps2_data_oe_o     (ps2_data_oe_o),
    .tx_data_i         (tx_data_i),
    .tx_write_i        (tx_write_i),
    .tx_write_ack_o    (tx_write_ack_o),
    .tx_error_no_ack_o (tx_error_no_ack_o),
    .timer_req_o       (timer_req),
    .timer_done_i      (timer_done),
    .rx_word_o         (rx_word)
  );

  // scan code register with the ready/read handshake
  ps2_rx_holding u_holding (
    .clk        (clk),
    .reset      (reset),
    .rx_word_i  (rx_word),
    .rx_read_i  (rx_read_i),
    .rx_code_o  (rx_code_o),
    .rx_ready_o (rx_ready_o)
  );

endmodule

`default_nettype wire

//--- dv/ps2_sva.sv
/*
 * PS/2 host port assertions on the host handshakes and line drivers
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_sva (
  input wire logic clk,
  input wire logic reset,
  input wire logic tx_write_ack_o,
  input wire logic rx_ready_o,
  input wire logic rx_read_i,
  input wire logic ps2_clk_oe_o,
  input wire logic ps2_data_oe_o
);

  // an accepted write passes the timer reset state and then pulls the clock
  ack_starts_inhibit: assert property (
    @(posedge clk) disable iff (reset) $past(tx_write_ack_o, 2) |-> ps2_clk_oe_o
  ) else $error("write acknowledge did not start the clock inhibit");

  // ready is cleared by the host alone
  ready_falls_on_read: assert property (
    @(posedge clk) disable iff (reset) $fell(rx_ready_o) |-> $past(rx_read_i)
  ) else $error("ready flag fell without a read pulse");

  // during inhibit only the clock is pulled, the start bit follows later
  no_double_pull: assert property (
    @(posedge clk) disable iff (reset) !(ps2_clk_oe_o && ps2_data_oe_o)
  ) else $error("clock and data pulled low together");

endmodule

bind ps2_host_top ps2_sva u_sva (
  .clk            (clk),
  .reset          (reset),
  .tx_write_ack_o (tx_write_ack_o),
  .rx_ready_o     (rx_ready_o),
  .rx_read_i      (rx_read_i),
  .ps2_clk_oe_o   (ps2_clk_oe_o),
  .ps2_data_oe_o  (ps2_data_oe_o)
);

`default_nettype wire

//--- dv/ps2_tb.sv
/*
 * PS/2 host port testbench: a device model drives and answers frames,
 * a reference function gives expected frames and scan codes
 */
`timescale 1ns/1ps
`default_nettype none

module ps2_tb;
  import ps2_pkg::*;

  // ------------------------------------------------------------------
  // run parameters
  // ------------------------------------------------------------------
  localparam int DIVIDE     = 4;
  // device clock half period in clk cycles
  localparam int HALF       = 40;
  localparam int INHIBIT_CYC = int'(INHIBIT_TICKS) * DIVIDE;
  // one frame plus the ack clock and some idle time
  localparam int FRAME_CYCLES = (FRAME_BITS + 1) * 2 * HALF;
  // 8 + 2 + 1 full receive frames, one partial, 5 transmits
  localparam int FRAME_COUNT  = 8 + 2 + 2 + 5;
  localparam int TIMEOUT_CYCLES = 2 * FRAME_COUNT * FRAME_CYCLES;

  logic       clk;
  logic       reset;
  divide_t    divide_i;
  logic       dev_clk_low;
  logic       dev_data_low;
  logic       ps2_clk_i;
  logic       ps2_data_i;
  logic       ps2_clk_oe_o;
  logic       ps2_data_oe_o;
  scan_code_t rx_code_o;
  logic       rx_ready_o;
  logic       rx_read_i;
  scan_code_t tx_data_i;
  logic       tx_write_i;
  logic       tx_write_ack_o;
  logic       tx_error_no_ack_o;

  int          errors;
  int          tests_run;
  int          tests_failed;
  int          test_start_errors;
  int          cycles;
  int          ack_count;
  int          err_cycles;
  logic [31:0] rng_state;
  logic        ready_prev;
  scan_code_t  expected_codes[$];

  // open-drain lines, low when either side pulls
  assign ps2_clk_i  = !(dev_clk_low || ps2_clk_oe_o);
  assign ps2_data_i = !(dev_data_low || ps2_data_oe_o);

  ps2_host_top uut (
    .clk               (clk),
    .reset             (reset),
    .divide_i          (divide_i),
    .ps2_clk_i         (ps2_clk_i),
    .ps2_data_i        (ps2_data_i),
    .ps2_clk_oe_o      (ps2_clk_oe_o),
    .ps2_data_oe_o     (ps2_data_oe_o),
    .rx_code_o         (rx_code_o),
    .rx_ready_o        (rx_ready_o),
    .rx_read_i         (rx_read_i),
    .tx_data_i         (tx_data_i),
    .tx_write_i        (tx_write_i),
    .tx_write_ack_o    (tx_write_ack_o),
    .tx_error_no_ack_o (tx_error_no_ack_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = !clk;
  end

  // ------------------------------------------------------------------
  // reference model and helpers
  // ------------------------------------------------------------------

  // wire order: start 0, data LSB first, odd parity, stop 1
  function automatic frame_t ref_frame(input scan_code_t b);
    frame_t f;
    int     ones;
    ones = 0;
    f[0] = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      f[i + 1] = b[i];
      if (b[i])
        ones++;
    end
    // the parity bit makes the count of ones over data and parity odd
    f[9]  = (ones % 2 == 0);
    f[10] = 1'b1;
    return f;
  endfunction

  // the first data bit on the wire is the LSB of the scan code
  function automatic scan_code_t ref_code(input frame_t f);
    scan_code_t c;
    for (int i = 0; i < 8; i++)
      c[i] = f[i + 1];
    return c;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic scan_code_t next_byte();
    rng_state = xorshift(rng_state);
    return rng_state[7:0];
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("error: %0t %s actual %0h expected %0h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic begin_test();
    test_start_errors = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_start_errors)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: FAILED", tests_run, name);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // the device sets data while its clock is high, the host samples on the fall
  task automatic send_frame(input scan_code_t b, input int nbits);
    frame_t f;
    f = ref_frame(b);
    for (int i = 0; i < nbits; i++)
    begin
      dev_data_low = !f[i];
      wait_cycles(HALF);
      dev_clk_low = 1'b1;
      wait_cycles(HALF);
      dev_clk_low = 1'b0;
    end
    dev_data_low = 1'b0;
    wait_cycles(HALF);
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!rx_ready_o && n < 2 * HALF)
    begin
      @(negedge clk);
      n++;
    end
    if (!rx_ready_o)
    begin
      $display("ready flag did not rise after a received frame at %0t", $time);
      errors++;
    end
  endtask

  task automatic read_pulse();
    rx_read_i = 1'b1;
    @(negedge clk);
    rx_read_i = 1'b0;
    @(negedge clk);
    check("rx_ready_o", rx_ready_o, 1'b0);
  endtask

  // host-to-device transfer, seen from the device side
  task automatic tx_transfer(input scan_code_t b, input logic give_ack);
    frame_t got;
    int     n;
    int     low_cycles;
    int     acks_before;
    int     err_before;
    logic   err_seen;
    acks_before = ack_count;
    err_before  = err_cycles;
    err_seen    = 1'b0;
    tx_data_i   = b;
    tx_write_i  = 1'b1;
    @(negedge clk);
    tx_write_i  = 1'b0;
    n = 0;
    while (!ps2_clk_oe_o && n < 20)
    begin
      @(negedge clk);
      n++;
    end
    low_cycles = 0;
    while (ps2_clk_oe_o && low_cycles < 4 * INHIBIT_CYC)
    begin
      @(negedge clk);
      low_cycles++;
    end
    if (low_cycles < INHIBIT_CYC)
    begin
      $display("clock inhibit too short, %0d cycles at %0t", low_cycles, $time);
      errors++;
    end
    // the device clocks 11 bits, the last low phase carries the ack
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      wait_cycles(HALF - 4);
      got[i] = ps2_data_i;
      if (i == FRAME_BITS - 1 && give_ack)
        dev_data_low = 1'b1;
      wait_cycles(4);
      dev_clk_low = 1'b1;
      wait_cycles(HALF / 2);
      if (i == FRAME_BITS - 1)
        err_seen = tx_error_no_ack_o;
      wait_cycles(HALF / 2);
      dev_clk_low  = 1'b0;
      dev_data_low = 1'b0;
    end
    wait_cycles(10);
    check("tx_frame", got, ref_frame(b));
    check("tx_write_ack_o count", ack_count - acks_before, 1);
    if (give_ack)
      check("tx_error_no_ack_o cycles", err_cycles - err_before, 0);
    else
      check("tx_error_no_ack_o", err_seen, 1'b1);
  endtask

  // ------------------------------------------------------------------
  // monitors and the receive compare process
  // ------------------------------------------------------------------

  // the write acknowledge is a combinational pulse that ends at the
  // next rising edge, so it is counted there
  always @(posedge clk)
  begin
    if (!reset && tx_write_ack_o)
      ack_count++;
  end

  always @(negedge clk)
  begin
    if (reset)
      ready_prev <= 1'b0;
    else
    begin
      ready_prev <= rx_ready_o;
      if (tx_error_no_ack_o)
        err_cycles++;
      if (rx_ready_o && !ready_prev)
      begin
        if (expected_codes.size() == 0)
        begin
          $display("ready flag rose with no frame expected at %0t", $time);
          errors++;
        end
        else
          check("rx_code_o", rx_code_o, expected_codes.pop_front());
      end
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout, the run went past %0d cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------
  initial
  begin
    scan_code_t b;
    scan_code_t b2;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cycles = 0;
    ack_count = 0;
    err_cycles = 0;
    rng_state = 32'd33;
    reset = 1'b1;
    divide_i = divide_t'(DIVIDE);
    dev_clk_low = 1'b0;
    dev_data_low = 1'b0;
    rx_read_i = 1'b0;
    tx_data_i = '0;
    tx_write_i = 1'b0;
    wait_cycles(2);
    reset = 1'b0;
    wait_cycles(2);

    begin_test();
    check("ps2_clk_oe_o", ps2_clk_oe_o, 1'b0);
    check("ps2_data_oe_o", ps2_data_oe_o, 1'b0);
    check("rx_ready_o", rx_ready_o, 1'b0);
    check("tx_write_ack_o", tx_write_ack_o, 1'b0);
    check("tx_error_no_ack_o", tx_error_no_ack_o, 1'b0);
    check("ps2_clk_i", ps2_clk_i, 1'b1);
    check("ps2_data_i", ps2_data_i, 1'b1);
    end_test("reset state");

    begin_test();
    for (int i = 0; i < 8; i++)
    begin
      b = next_byte();
      expected_codes.push_back(ref_code(ref_frame(b)));
      send_frame(b, FRAME_BITS);
      wait_ready();
      read_pulse();
    end
    end_test("receive");

    // the second code replaces the first, ready never drops in between
    begin_test();
    b = next_byte();
    b2 = next_byte();
    expected_codes.push_back(ref_code(ref_frame(b)));
    send_frame(b, FRAME_BITS);
    wait_ready();
    send_frame(b2, FRAME_BITS);
    check("rx_ready_o", rx_ready_o, 1'b1);
    check("rx_code_o", rx_code_o, ref_code(ref_frame(b2)));
    read_pulse();
    end_test("back-pressure");

    begin_test();
    send_frame(next_byte(), 4);
    wait_cycles(4 * INHIBIT_CYC);
    b = next_byte();
    expected_codes.push_back(ref_code(ref_frame(b)));
    send_frame(b, FRAME_BITS);
    wait_ready();
    read_pulse();
    end_test("watchdog");

    begin_test();
    for (int i = 0; i < 4; i++)
      tx_transfer(next_byte(), 1'b1);
    end_test("transmit");

    begin_test();
    tx_transfer(next_byte(), 1'b0);
    end_test("no ack");

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
hdl/ps2_pkg.sv
hdl/ps2_tick_timer.sv
hdl/ps2_frame_engine.sv
hdl/ps2_rx_holding.sv
hdl/ps2_host_top.sv
dv/ps2_sva.sv
dv/ps2_tb.sv

//--- Makefile
# Verilator build and run for the PS/2 host port

LOG := sim.log

.PHONY: run lint clean

run: obj_dir/Vps2_tb
	./obj_dir/Vps2_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "All tests passed!" $(LOG) || { echo "simulation did not complete"; exit 1; }

obj_dir/Vps2_tb: src.f $(wildcard hdl/*.sv dv/*.sv)
	verilator --binary --timing --assert -f src.f --top-module ps2_tb

lint:
	verilator --lint-only -Wall --timing hdl/ps2_pkg.sv hdl/ps2_tick_timer.sv \
		hdl/ps2_frame_engine.sv hdl/ps2_rx_holding.sv hdl/ps2_host_top.sv \
		--top-module ps2_host_top

clean:
	rm -rf obj_dir $(LOG)
